// ==== matrix_frame_testdata.txt ====
// Word: tag digit, then fields. 1Gxxbb sends bb (G=1 adds a random gap), 20nnnn idles n,
// 30nnnn waits up to n cycles for done, 4RCPee reads and expects ee, 5000BD busy and done.
// Test 1: state after reset.
500000
400000 400100 400200 401000 401100 401200 402000 402100 402200 403000 403100 403200
410000 410100 410200 411000 411100 411200 412000 412100 412200 413000 413100 413200
F00001
// Test 2: READFRAME with gaps, byte k is 10+k.
100001
110010 110011 110012 110013 110014 110015 110016 110017 110018 110019 11001A 11001B
11001C 11001D 11001E 11001F 110020 110021 110022 110023 110024 110025 110026 110027
300004 500000
400012 400111 400210 401015 401114 401213 402018 402117 402216 40301B 40311A 403219
41001E 41011D 41021C 411021 411120 41121F 412024 412123 412222 413027 413126 413225
F00002
// Test 3: FILL with 3C, done within 26 cycles of the value byte.
100002 10003C 500010 30001A 500000
40003C 40013C 40023C 40103C 40113C 40123C 40203C 40213C 40223C 40303C 40313C 40323C
41003C 41013C 41023C 41103C 41113C 41123C 41203C 41213C 41223C 41303C 41313C 41323C
F00003
// Test 4: unknown opcodes change nothing.
1000A5 500000 100000 200003 500000
40003C 40013C 40023C 40103C 40113C 40123C 40203C 40213C 40223C 40303C 40313C 40323C
41003C 41013C 41023C 41103C 41113C 41123C 41203C 41213C 41223C 41303C 41313C 41323C
F00004
// Test 5: bytes during a FILL are dropped, then a READFRAME with byte k = A0+k.
100002 10005A 100001 1000C3 1000C4 100001 500010 300020 500000
40005A 40015A 40025A 40105A 40115A 40125A 40205A 40215A 40225A 40305A 40315A 40325A
41005A 41015A 41025A 41105A 41115A 41125A 41205A 41215A 41225A 41305A 41315A 41325A
100001
1100A0 1100A1 1100A2 1100A3 1100A4 1100A5 1100A6 1100A7 1100A8 1100A9 1100AA 1100AB
1100AC 1100AD 1100AE 1100AF 1100B0 1100B1 1100B2 1100B3 1100B4 1100B5 1100B6 1100B7
300004 500000
4000A2 4001A1 4002A0 4010A5 4011A4 4012A3 4020A8 4021A7 4022A6 4030AB 4031AA 4032A9
4100AE 4101AD 4102AC 4110B1 4111B0 4112AF 4120B4 4121B3 4122B2 4130B7 4131B6 4132B5
F00005
// Test 6: two frames back to back, only the second (C0+k) remains.
100001
110030 110031 110032 110033 110034 110035 110036 110037 110038 110039 11003A 11003B
11003C 11003D 11003E 11003F 110040 110041 110042 110043 110044 110045 110046 110047
300004 500000 100001
1100C0 1100C1 1100C2 1100C3 1100C4 1100C5 1100C6 1100C7 1100C8 1100C9 1100CA 1100CB
1100CC 1100CD 1100CE 1100CF 1100D0 1100D1 1100D2 1100D3 1100D4 1100D5 1100D6 1100D7
300004 500000
4000C2 4001C1 4002C0 4010C5 4011C4 4012C3 4020C8 4021C7 4022C6 4030CB 4031CA 4032C9
4100CE 4101CD 4102CC 4110D1 4111D0 4112CF 4120D4 4121D3 4122D2 4130D7 4131D6 4132D5
F00006

// ==== matrix_frame.f ====
params.sv
types.sv
fb_write_if.sv
control_cmd_readframe.sv
control_cmd_fill.sv
control_cmd_decode.sv
framebuffer.sv
matrix_frame_top.sv
matrix_frame_sva.sv
matrix_frame_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the frame loader testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f matrix_frame.f --top-module matrix_frame_tb \
    -o matrix_frame_sim

output=$(./obj_dir/matrix_frame_sim)
echo "$output"

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// ==== matrix_frame_tb.sv ====
/* Testbench for the frame loader. Commands, idle gaps and expected read-back values
   come from matrix_frame_testdata.txt, which must be reachable from the run directory. */
`timescale 1ns/1ns

module matrix_frame_tb;

    import types::*;

    localparam int SCRIPT_DEPTH = 512;
    localparam int RESET_CYCLES = 5;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic        enable;
    row_addr_t   read_row;
    col_addr_t   read_col;
    pixel_addr_t read_pixel;
    logic        busy;
    logic        done;
    logic [7:0]  read_data;

    logic [23:0] script [SCRIPT_DEPTH];
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_passed;

    matrix_frame_top matrix_frame_top_i (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .enable     (enable),
        .read_row   (read_row),
        .read_col   (read_col),
        .read_pixel (read_pixel),
        .busy       (busy),
        .done       (done),
        .read_data  (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [7:0] actual,
                         input logic [7:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    // One strobed byte. A gapped byte waits 0 to 3 idle cycles first.
    task automatic send_byte(input logic [7:0] value, input logic gapped);
        int gap;
        gap = gapped ? int'($urandom % 4) : 0;
        repeat (gap) @(negedge clk);
        data_in = value;
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while ((done !== 1'b1) && (cycles < limit)) begin
            @(negedge clk);
            cycles++;
        end
        if (done === 1'b1) begin
            @(negedge clk);  // The dispatcher is back in idle one cycle after done.
        end else begin
            $display("timeout: done did not arrive within %0d cycles", limit);
            errors++;
            test_errors++;
        end
    endtask

    task automatic read_compare(input row_addr_t row, input col_addr_t col,
                                input pixel_addr_t pixel, input logic [7:0] expected);
        string name;
        name = $sformatf("read_data[%0d][%0d][%0d]", row, col, pixel);
        read_row = row;
        read_col = col;
        read_pixel = pixel;
        @(negedge clk);  // Registered read port.
        check(name, read_data, expected);
    endtask

    task automatic check_status(input logic busy_exp, input logic done_exp);
        check("busy", {7'b0, busy}, {7'b0, busy_exp});
        check("done", {7'b0, done}, {7'b0, done_exp});
    endtask

    task automatic finish_test(input int number);
        tests_run++;
        if (test_errors == 0) tests_passed++;
        $display("test %0d finished with %0d errors", number, test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [23:0] word;
        reset = 1'b1;
        enable = 1'b0;
        data_in = 8'd0;
        read_row = '0;
        read_col = '0;
        read_pixel = '0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_passed = 0;
        void'($urandom(34527));
        foreach (script[i]) script[i] = '0;
        $readmemh("matrix_frame_testdata.txt", script);
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // A zero word marks the end of the script.
        for (int pc = 0; pc < SCRIPT_DEPTH; pc++) begin
            word = script[pc];
            if (word[23:20] == 4'h0) break;
            case (word[23:20])
                4'h1: send_byte(word[7:0], word[16]);
                4'h2: repeat (int'(word[15:0])) @(negedge clk);
                4'h3: wait_done(int'(word[15:0]));
                4'h4: read_compare(row_addr_t'(word[19:16]), col_addr_t'(word[15:12]),
                                   pixel_addr_t'(word[11:8]), word[7:0]);
                4'h5: check_status(word[4], word[0]);
                4'hf: finish_test(int'(word[7:0]));
                default: begin
                    $display("data file entry %0d holds an unknown command %h", pc, word);
                    errors++;
                end
            endcase
        end

        $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_passed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== matrix_frame_sva.sv ====
/* Protocol assertions for the frame loader, bound into the top level.
   They watch the shared frame-buffer write link fb_wr. */
`timescale 1ns/1ns

module matrix_frame_sva (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done,
    input logic write_enable,
    input logic access_start
);

    done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        !(done && $past(done)))
        else $error("done was high for two cycles in a row");

    // First edge after reset is released.
    busy_low_after_reset: assert property (@(posedge clk)
        !(($past(reset) === 1'b1) && (reset === 1'b0)) || (busy === 1'b0))
        else $error("busy was high in the cycle after reset");

    toggle_needs_enable: assert property (@(posedge clk) disable iff (reset)
        (access_start == $past(access_start)) || write_enable)
        else $error("access_start toggled while write_enable was low");

endmodule

bind matrix_frame_top matrix_frame_sva sva_i (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .done         (done),
    .write_enable (fb_wr.write_enable),
    .access_start (fb_wr.access_start)
);

// ==== matrix_frame_top.sv ====
/* LED matrix frame loader. Commands arrive as enable-strobed bytes on data_in and
   the stored frame is read back one byte at a time with one cycle of latency. */
`timescale 1ns/1ns

module matrix_frame_top (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         data_in,
    input  logic               enable,
    input  types::row_addr_t   read_row,
    input  types::col_addr_t   read_col,
    input  types::pixel_addr_t read_pixel,
    output logic               busy,
    output logic               done,
    output logic [7:0]         read_data
);

    import types::*;

    fb_addr_t read_addr;

    fb_write_if fb_wr ();

    assign read_addr = '{row: read_row, col: read_col, pixel: read_pixel};

    control_cmd_decode decode_i (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .data_in (data_in),
        .fb      (fb_wr),
        .busy    (busy),
        .done    (done)
    );

    framebuffer framebuffer_i (
        .clk       (clk),
        .reset     (reset),
        .fb        (fb_wr),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

// ==== framebuffer.sv ====
/* Byte store for one frame. Contents clear on reset, so it maps to flops. Addresses
   outside the frame are not written and read back as zero. */
`timescale 1ns/1ns

module framebuffer (
    input  logic            clk,
    input  logic            reset,
    fb_write_if.buffer      fb,
    input  types::fb_addr_t read_addr,
    output logic [7:0]      read_data
);

    import params::*;
    import types::*;

    localparam int IDX_W = (FRAME_BYTES > 1) ? $clog2(FRAME_BYTES) : 1;

    typedef logic [IDX_W-1:0] idx_t;

    logic [7:0] mem [FRAME_BYTES];
    logic       last_toggle;
    logic       write_hit;
    int         write_pos;
    int         read_pos;

    // Linear byte position of an address.
    function automatic int lin_pos(fb_addr_t a);
        return (int'(a.row) * PIXEL_WIDTH + int'(a.col)) * BYTES_PER_PIXEL + int'(a.pixel);
    endfunction

    // A field past its dimension would alias another byte's position.
    function automatic logic in_frame(fb_addr_t a);
        return (int'(a.row) < PIXEL_HEIGHT) && (int'(a.col) < PIXEL_WIDTH) &&
               (int'(a.pixel) < BYTES_PER_PIXEL);
    endfunction

    assign write_pos = lin_pos(fb.addr);
    assign read_pos = lin_pos(read_addr);
    assign write_hit = fb.write_enable && (fb.access_start != last_toggle) &&
                       in_frame(fb.addr);

    always_ff @(posedge clk) begin
        if (reset) last_toggle <= 1'b0;
        else last_toggle <= fb.access_start;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FRAME_BYTES; i++) begin
                mem[i] <= 8'd0;
            end
        end else if (write_hit) begin
            mem[idx_t'(write_pos)] <= fb.data;
        end
    end

    always_ff @(posedge clk) begin
        read_data <= in_frame(read_addr) ? mem[idx_t'(read_pos)] : 8'd0;
    end

endmodule

// ==== control_cmd_decode.sv ====
/* Opcode dispatcher. Bytes that arrive while a FILL is being written are dropped,
   and busy stays high from the cycle after the opcode until done. */
`timescale 1ns/1ns

module control_cmd_decode (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    fb_write_if.writer fb,
    output logic       busy,
    output logic       done
);

    import types::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL_VALUE,
        ST_FRAME,
        ST_FILL
    } state_t;

    state_t     state;
    logic       frame_start;
    logic       frame_enable;
    logic       frame_done;
    logic       fill_start;
    logic       fill_done;
    logic [7:0] fill_value;

    fb_write_if frame_wr ();
    fb_write_if fill_wr ();

    // The reader primes in the opcode cycle so that a byte in the very next cycle counts.
    assign frame_start = (state == ST_IDLE) && enable && (cmd_op_t'(data_in) == CMD_READFRAME);
    assign frame_enable = enable && (state == ST_FRAME);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            fill_start <= 1'b0;
        end else begin
            fill_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (enable) begin
                        case (cmd_op_t'(data_in))
                            CMD_READFRAME: state <= ST_FRAME;
                            CMD_FILL:      state <= ST_FILL_VALUE;
                            default:       state <= ST_IDLE;  // Unknown opcodes are ignored.
                        endcase
                    end
                end
                ST_FILL_VALUE: begin
                    if (enable) begin
                        fill_start <= 1'b1;
                        state <= ST_FILL;
                    end
                end
                ST_FRAME: begin
                    if (frame_done) state <= ST_IDLE;
                end
                ST_FILL: begin
                    if (fill_done) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_FILL_VALUE) && enable) fill_value <= data_in;
    end

    control_cmd_readframe readframe_i (
        .clk     (clk),
        .reset   (reset),
        .enable  (frame_enable),
        .data_in (data_in),
        .start   (frame_start),
        .fb      (frame_wr),
        .done    (frame_done)
    );

    control_cmd_fill fill_i (
        .clk   (clk),
        .reset (reset),
        .start (fill_start),
        .value (fill_value),
        .fb    (fill_wr),
        .done  (fill_done)
    );

    // Each engine toggles only for its own writes, so the XOR carries every write exactly once.
    always_comb begin
        fb.access_start = frame_wr.access_start ^ fill_wr.access_start;
        fb.write_enable = frame_wr.write_enable | fill_wr.write_enable;
        if (fill_wr.write_enable) begin
            fb.addr = fill_wr.addr;
            fb.data = fill_wr.data;
        end else begin
            fb.addr = frame_wr.addr;
            fb.data = frame_wr.data;
        end
    end

    assign done = frame_done | fill_done;
    assign busy = (state != ST_IDLE) && !done;

endmodule

// ==== control_cmd_fill.sv ====
/* Writes one value to every frame-buffer byte, one per cycle, in load order.
   done pulses one cycle after the last write is presented. */
`timescale 1ns/1ns

module control_cmd_fill (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [7:0] value,
    fb_write_if.writer fb,
    output logic       done
);

    import types::*;

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            fb.write_enable <= 1'b0;
            fb.access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        fb.write_enable <= 1'b1;
                        fb.access_start <= !fb.access_start;  // First byte.
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (addr_is_last(fb.addr)) begin
                        fb.write_enable <= 1'b0;
                        done <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        fb.access_start <= !fb.access_start;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && start) begin
            fb.addr <= addr_first();
            fb.data <= value;
        end else if ((state == ST_WRITE) && !addr_is_last(fb.addr)) begin
            fb.addr <= addr_step(fb.addr);
        end
    end

endmodule

// ==== control_cmd_readframe.sv ====
/* Turns one frame of strobed bytes into addressed writes. The source must send
   exactly FRAME_BYTES bytes after the start pulse; there is no flow control. */
`timescale 1ns/1ns

module control_cmd_readframe (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    input  logic       start,
    fb_write_if.writer fb,
    output logic       done
);

    import types::*;

    typedef enum logic [1:0] {
        ST_WAIT_START,
        ST_READ_FRAME,
        ST_DONE
    } state_t;

    state_t   state;
    fb_addr_t next_addr;  // Address of the next byte to arrive.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_WAIT_START;
            fb.write_enable <= 1'b0;
            fb.access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_WAIT_START: begin
                    if (start) state <= ST_READ_FRAME;
                end
                ST_READ_FRAME: begin
                    if (enable) begin
                        fb.write_enable <= 1'b1;
                        fb.access_start <= !fb.access_start;
                        if (addr_is_last(next_addr)) state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // Last byte is on the bus this cycle.
                    done <= 1'b1;
                    fb.write_enable <= 1'b0;
                    state <= ST_WAIT_START;
                end
                default: state <= ST_WAIT_START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_WAIT_START) && start) begin
            next_addr <= addr_first();
        end else if ((state == ST_READ_FRAME) && enable) begin
            fb.addr <= next_addr;
            fb.data <= data_in;
            if (!addr_is_last(next_addr)) next_addr <= addr_step(next_addr);
        end
    end

endmodule

// ==== fb_write_if.sv ====
/* One frame-buffer write request. A write takes place when access_start changes
   while write_enable is high; addr and data are sampled in that same cycle. */
`timescale 1ns/1ns

interface fb_write_if;

    import types::*;

    fb_addr_t   addr;
    logic [7:0] data;
    logic       write_enable;
    logic       access_start;  // Toggles once per byte.

    modport writer (output addr, output data, output write_enable, output access_start);
    modport buffer (input addr, input data, input write_enable, input access_start);

endinterface

// ==== types.sv ====
/* Address, opcode and address-stepping definitions shared by the command engines.
   Frames load row by row, column by column, and each pixel from its highest byte down. */
package types;

    import params::*;

    localparam int ROW_W = (PIXEL_HEIGHT > 1) ? $clog2(PIXEL_HEIGHT) : 1;
    localparam int COL_W = (PIXEL_WIDTH > 1) ? $clog2(PIXEL_WIDTH) : 1;
    localparam int PIX_W = (BYTES_PER_PIXEL > 1) ? $clog2(BYTES_PER_PIXEL) : 1;

    typedef logic [ROW_W-1:0] row_addr_t;
    typedef logic [COL_W-1:0] col_addr_t;
    typedef logic [PIX_W-1:0] pixel_addr_t;

    typedef struct packed {
        row_addr_t   row;
        col_addr_t   col;
        pixel_addr_t pixel;
    } fb_addr_t;

    typedef enum logic [7:0] {
        CMD_READFRAME = 8'd1,
        CMD_FILL      = 8'd2
    } cmd_op_t;

    // Address of the first byte in a frame.
    function automatic fb_addr_t addr_first();
        fb_addr_t a;
        a.row = '0;
        a.col = '0;
        a.pixel = pixel_addr_t'(BYTES_PER_PIXEL - 1);
        return a;
    endfunction

    function automatic logic addr_is_last(fb_addr_t a);
        return (a.row == row_addr_t'(PIXEL_HEIGHT - 1)) &&
               (a.col == col_addr_t'(PIXEL_WIDTH - 1)) &&
               (a.pixel == '0);
    endfunction

    // Next address in load order. Wraps past the last address.
    function automatic fb_addr_t addr_step(fb_addr_t a);
        fb_addr_t n;
        n = a;
        if (a.pixel != '0) begin
            n.pixel = a.pixel - pixel_addr_t'(1);
        end else begin
            n.pixel = pixel_addr_t'(BYTES_PER_PIXEL - 1);
            if (a.col == col_addr_t'(PIXEL_WIDTH - 1)) begin
                n.col = '0;
                n.row = a.row + row_addr_t'(1);
            end else begin
                n.col = a.col + col_addr_t'(1);
            end
        end
        return n;
    endfunction

endpackage

// ==== params.sv ====
/* Frame geometry of the LED matrix. All address widths in package types follow
   from these values, so a new panel size is set here only. */
package params;

    localparam int PIXEL_WIDTH = 4;      // Columns.
    localparam int PIXEL_HEIGHT = 2;     // Rows.
    localparam int BYTES_PER_PIXEL = 3;  // Colour bytes in one pixel.

    // Bytes held by the frame buffer.
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;

endpackage
